//--- eth_pkg.sv
`default_nettype none

package eth_pkg;

    // MAC payload buffer
    localparam int PAYLOAD_ADDR_W = 6;
    localparam int PAYLOAD_MAX    = 64;

    // payload length exactly as the MAC reports it
    typedef logic [15:0] udp_len_t;

    // command FIFO between gmii_rxc and clk
    localparam int FIFOC_DEPTH  = 64;
    localparam int FIFOC_ADDR_W = $clog2(FIFOC_DEPTH);

    // extra msb tells a full FIFO from an empty one
    typedef logic [FIFOC_ADDR_W:0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    // frame = header, nine register bytes, xor checksum
    localparam logic [7:0] FRAME_HEADER = 8'h55;
    localparam int         FRAME_LEN    = 11;
    localparam int         CMD_BYTES    = 9;

    // led pager
    localparam logic [7:0] LED_ID    = 8'h1B;
    localparam int         LED_PAGES = 3;

    // first frame byte after the header sits in the lowest byte
    typedef struct packed {
        logic [7:0] cmd_reg7;
        logic [7:0] cmd_reg6;
        logic [7:0] cmd_reg5;
        logic [7:0] cmd_reg4;
        logic [7:0] cmd_mix1;
        logic [7:0] cmd_mix0;
        logic [7:0] cmd_filt;
        logic [7:0] info_sr;
        logic [7:0] kind_dev;
    } cmd_fields_t;

    // parser fills by index, consumers read by name
    typedef union packed {
        logic [CMD_BYTES-1:0][7:0] bytes;
        cmd_fields_t               f;
    } cmd_regs_u;

    typedef struct packed {
        logic [7:0] ok_count;
        logic [7:0] err_count;
    } frame_cnt_t;

endpackage

`default_nettype wire

//--- mac2fifoc.sv
`timescale 1ns/1ps
`default_nettype none

module mac2fifoc (
    input  logic                               gmii_rxc,
    input  logic                               rst_n,
    input  logic                               fs,
    output logic                               fd,
    input  logic [7:0]                         udp_rxd,
    output logic [eth_pkg::PAYLOAD_ADDR_W-1:0] udp_rx_addr,
    input  eth_pkg::udp_len_t                  udp_rx_len,
    output logic [7:0]                         fifoc_txd,
    output logic                               fifoc_txen,
    output eth_pkg::udp_len_t                  dev_rx_len
);

    typedef enum logic [1:0] {S_IDLE, S_COPY, S_DONE} state_t;
    typedef logic [eth_pkg::PAYLOAD_ADDR_W:0] cnt_t;

    state_t     state;
    logic [1:0] fs_sync;
    cnt_t       remain;
    logic       rd_pend;

    // buffer answers one cycle after the address, straight into the FIFO
    assign fifoc_txd  = udp_rxd;
    assign fifoc_txen = rd_pend;

    always_ff @(posedge gmii_rxc or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            fs_sync     <= '0;
            fd          <= 1'b0;
            remain      <= '0;
            rd_pend     <= 1'b0;
            udp_rx_addr <= '0;
            dev_rx_len  <= '0;
        end else begin
            fs_sync <= {fs_sync[0], fs};
            case (state)
                S_IDLE: begin
                    if (fs_sync[1]) begin
                        // length kept as reported, parser rejects odd sizes
                        dev_rx_len  <= udp_rx_len;
                        remain      <= (udp_rx_len > eth_pkg::PAYLOAD_MAX) ?
                                       cnt_t'(eth_pkg::PAYLOAD_MAX) : cnt_t'(udp_rx_len);
                        udp_rx_addr <= '0;
                        state       <= S_COPY;
                    end
                end
                S_COPY: begin
                    rd_pend <= (remain != '0);
                    if (remain != '0) begin
                        remain      <= remain - 1'b1;
                        udp_rx_addr <= udp_rx_addr + 1'b1;
                    end else begin
                        // last byte is written on this edge
                        fd    <= 1'b1;
                        state <= S_DONE;
                    end
                end
                default: begin
                    if (!fs_sync[1]) begin
                        fd    <= 1'b0;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fifoc.sv
`timescale 1ns/1ps
`default_nettype none

module fifoc (
    input  logic       wr_clk,
    input  logic       rd_clk,
    input  logic       rst_n,
    input  logic [7:0] din,
    input  logic       wr_en,
    output logic [7:0] dout,
    input  logic       rd_en,
    output logic       full,
    output logic       empty
);

    logic [7:0] mem [eth_pkg::FIFOC_DEPTH];

    eth_pkg::fifo_ptr_t wr_bin;
    eth_pkg::fifo_ptr_t wr_gray;
    eth_pkg::fifo_ptr_t wr_bin_nxt;
    eth_pkg::fifo_ptr_t rd_bin;
    eth_pkg::fifo_ptr_t rd_gray;
    eth_pkg::fifo_ptr_t rd_bin_nxt;
    // read pointer seen from the write side, and the reverse
    eth_pkg::fifo_ptr_t rd_gray_w1;
    eth_pkg::fifo_ptr_t rd_gray_w2;
    eth_pkg::fifo_ptr_t wr_gray_r1;
    eth_pkg::fifo_ptr_t wr_gray_r2;

    function automatic eth_pkg::fifo_ptr_t to_gray(input eth_pkg::fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    assign wr_bin_nxt = wr_bin + 1'b1;
    assign rd_bin_nxt = rd_bin + 1'b1;

    // full: top two gray bits inverted, rest equal
    assign full  = (wr_gray == {~rd_gray_w2[eth_pkg::FIFOC_ADDR_W -: 2],
                                rd_gray_w2[eth_pkg::FIFOC_ADDR_W-2:0]});
    assign empty = (rd_gray == wr_gray_r2);

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
            if (wr_en && !full) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= to_gray(wr_bin_nxt);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en && !full) begin
            mem[wr_bin[eth_pkg::FIFOC_ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
            if (rd_en && !empty) begin
                rd_bin  <= rd_bin_nxt;
                rd_gray <= to_gray(rd_bin_nxt);
            end
        end
    end

    // registered read, dout one cycle after rd_en
    always_ff @(posedge rd_clk) begin
        if (rd_en && !empty) begin
            dout <= mem[rd_bin[eth_pkg::FIFOC_ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- fifoc2cs.sv
`timescale 1ns/1ps
`default_nettype none

module fifoc2cs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fs,
    output logic               fd,
    output logic               fifoc_rxen,
    input  logic [7:0]         fifoc_rxd,
    input  logic               fifoc_empty,
    input  eth_pkg::udp_len_t  data_len,
    output logic               frame_ok,
    output cmd_pkg::cmd_regs_u regs_img
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_DONE} state_t;
    typedef logic [eth_pkg::PAYLOAD_ADDR_W:0] cnt_t;

    state_t     state;
    logic [1:0] fs_sync;
    cnt_t       frame_bytes;
    cnt_t       to_read;
    cnt_t       to_recv;
    cnt_t       byte_idx;
    logic       rd_vld;
    logic       in_regs;
    logic       len_ok;
    logic       hdr_ok;
    logic       chk_ok;
    logic [7:0] xor_acc;

    // only what the copier stored is in the FIFO
    assign frame_bytes = (data_len > eth_pkg::PAYLOAD_MAX) ?
                         cnt_t'(eth_pkg::PAYLOAD_MAX) : cnt_t'(data_len);

    assign fifoc_rxen = (state == S_READ) && (to_read != '0) && !fifoc_empty;
    assign in_regs    = (byte_idx != '0) && (byte_idx <= cmd_pkg::CMD_BYTES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            fs_sync  <= '0;
            fd       <= 1'b0;
            frame_ok <= 1'b0;
            to_read  <= '0;
            to_recv  <= '0;
            byte_idx <= '0;
            rd_vld   <= 1'b0;
            len_ok   <= 1'b0;
            hdr_ok   <= 1'b0;
            chk_ok   <= 1'b0;
            xor_acc  <= '0;
        end else begin
            fs_sync <= {fs_sync[0], fs};
            rd_vld  <= fifoc_rxen;
            case (state)
                S_IDLE: begin
                    if (fs_sync[1]) begin
                        to_read  <= frame_bytes;
                        to_recv  <= frame_bytes;
                        len_ok   <= (data_len == cmd_pkg::FRAME_LEN);
                        byte_idx <= '0;
                        hdr_ok   <= 1'b0;
                        chk_ok   <= 1'b0;
                        xor_acc  <= '0;
                        state    <= S_READ;
                    end
                end
                S_READ: begin
                    if (fifoc_rxen) begin
                        to_read <= to_read - 1'b1;
                    end
                    if (rd_vld) begin
                        to_recv  <= to_recv - 1'b1;
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == '0) begin
                            hdr_ok <= (fifoc_rxd == cmd_pkg::FRAME_HEADER);
                        end else if (in_regs) begin
                            xor_acc <= xor_acc ^ fifoc_rxd;
                        end else if (byte_idx == cmd_pkg::FRAME_LEN - 1) begin
                            chk_ok <= (fifoc_rxd == xor_acc);
                        end
                    end else if (to_recv == '0) begin
                        // whole length drained, good or bad
                        frame_ok <= len_ok && hdr_ok && chk_ok;
                        fd       <= 1'b1;
                        state    <= S_DONE;
                    end
                end
                default: begin
                    if (!fs_sync[1]) begin
                        fd       <= 1'b0;
                        frame_ok <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // frame bytes 1..9 land in image bytes 0..8
    always_ff @(posedge clk) begin
        if (rd_vld && in_regs) begin
            regs_img.bytes[byte_idx - 1'b1] <= fifoc_rxd;
        end
    end

endmodule

`default_nettype wire

//--- cs.sv
`timescale 1ns/1ps
`default_nettype none

module cs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fd_udp_rx,
    output logic                fs_udp_rx,
    output logic                fs_mac2fifoc,
    input  logic                fd_mac2fifoc,
    output logic                fs_fifoc2cs,
    input  logic                fd_fifoc2cs,
    input  logic                frame_ok,
    input  cmd_pkg::cmd_regs_u  regs_img,
    output logic                err_fifoc2cs,
    output cmd_pkg::cmd_regs_u  cmd_regs,
    output cmd_pkg::frame_cnt_t frame_cnt
);

    typedef enum logic [1:0] {S_IDLE, S_COPY, S_PARSE, S_RELEASE} state_t;

    state_t     state;
    // bit 1 fd_udp_rx, bit 0 fd_mac2fifoc, both from gmii_rxc
    logic [1:0] sync_q1;
    logic [1:0] sync_q2;
    logic       rx_req;
    logic       copy_done;
    logic       rx_armed;

    assign rx_req    = sync_q2[1];
    assign copy_done = sync_q2[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            sync_q1      <= '0;
            sync_q2      <= '0;
            rx_armed     <= 1'b0;
            fs_udp_rx    <= 1'b0;
            fs_mac2fifoc <= 1'b0;
            fs_fifoc2cs  <= 1'b0;
            err_fifoc2cs <= 1'b0;
            cmd_regs     <= '0;
            frame_cnt    <= '0;
        end else begin
            sync_q1      <= {fd_udp_rx, fd_mac2fifoc};
            sync_q2      <= sync_q1;
            err_fifoc2cs <= 1'b0;
            // the MAC must drop its level before the next payload counts
            if (!rx_req) begin
                rx_armed <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (rx_req && rx_armed) begin
                        rx_armed     <= 1'b0;
                        fs_udp_rx    <= 1'b0;
                        fs_mac2fifoc <= 1'b1;
                        state        <= S_COPY;
                    end else begin
                        fs_udp_rx <= 1'b1;
                    end
                end
                S_COPY: begin
                    if (copy_done) begin
                        fs_mac2fifoc <= 1'b0;
                        fs_fifoc2cs  <= 1'b1;
                        state        <= S_PARSE;
                    end
                end
                S_PARSE: begin
                    if (fd_fifoc2cs) begin
                        fs_fifoc2cs <= 1'b0;
                        if (frame_ok) begin
                            cmd_regs           <= regs_img;
                            frame_cnt.ok_count <= frame_cnt.ok_count + 1'b1;
                        end else begin
                            err_fifoc2cs        <= 1'b1;
                            frame_cnt.err_count <= frame_cnt.err_count + 1'b1;
                        end
                        state <= S_RELEASE;
                    end
                end
                default: begin
                    // both done levels back low before taking a new payload
                    if (!fd_fifoc2cs && !copy_done) begin
                        fs_udp_rx <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- led.sv
`timescale 1ns/1ps
`default_nettype none

module led (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                up,
    input  logic                down,
    input  cmd_pkg::cmd_regs_u  cmd_regs,
    input  cmd_pkg::frame_cnt_t frame_cnt,
    output logic [31:0]         led
);

    logic [1:0]       page;
    logic [11:0][7:0] view;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page <= '0;
        end else if (up) begin
            page <= (page == 2'(cmd_pkg::LED_PAGES - 1)) ? '0 : page + 2'd1;
        end else if (down) begin
            page <= (page == '0) ? 2'(cmd_pkg::LED_PAGES - 1) : page - 2'd1;
        end
    end

    // registers, then ok, err, board id on top
    assign view = {cmd_pkg::LED_ID, frame_cnt.err_count, frame_cnt.ok_count,
                   cmd_regs.bytes};

    always_comb begin
        case (page)
            2'd1:    led = view[7:4];
            2'd2:    led = view[11:8];
            default: led = view[3:0];
        endcase
    end

endmodule

`default_nettype wire

//--- cmd_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_rx_top (
    input  logic                               gmii_rxc,
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [7:0]                         udp_rxd,
    input  eth_pkg::udp_len_t                  udp_rx_len,
    input  logic                               fd_udp_rx,
    input  logic                               up,
    input  logic                               down,
    output logic                               fs_udp_rx,
    output logic [eth_pkg::PAYLOAD_ADDR_W-1:0] udp_rx_addr,
    output cmd_pkg::cmd_regs_u                 cmd_regs,
    output cmd_pkg::frame_cnt_t                frame_cnt,
    output logic                               err_fifoc2cs,
    output logic                               fifoc_full,
    output logic [31:0]                        led
);

    logic               fs_mac2fifoc;
    logic               fd_mac2fifoc;
    logic               fs_fifoc2cs;
    logic               fd_fifoc2cs;
    logic [7:0]         fifoc_txd;
    logic               fifoc_txen;
    logic [7:0]         fifoc_rxd;
    logic               fifoc_rxen;
    logic               fifoc_empty;
    eth_pkg::udp_len_t  dev_rx_len;
    logic               frame_ok;
    cmd_pkg::cmd_regs_u regs_img;

    // gmii_rxc side
    mac2fifoc mac2fifoc_dut (
        .*,
        .fs(fs_mac2fifoc),
        .fd(fd_mac2fifoc)
    );

    fifoc fifoc_dut (
        .wr_clk(gmii_rxc),
        .rd_clk(clk),
        .rst_n(rst_n),
        .din(fifoc_txd),
        .wr_en(fifoc_txen),
        .dout(fifoc_rxd),
        .rd_en(fifoc_rxen),
        .full(fifoc_full),
        .empty(fifoc_empty)
    );

    // clk side
    fifoc2cs fifoc2cs_dut (
        .*,
        .fs(fs_fifoc2cs),
        .fd(fd_fifoc2cs),
        .data_len(dev_rx_len)
    );

    cs cs_dut (.*);

    led led_dut (.*);

endmodule

`default_nettype wire

//--- cmd_rx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_rx_sva (
    input logic clk,
    input logic gmii_rxc,
    input logic rst_n,
    input logic fs_udp_rx,
    input logic fs_mac2fifoc,
    input logic fs_fifoc2cs,
    input logic fifoc_txen,
    input logic fifoc_full
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // copy and parse are never requested together
    a_fs_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(fs_mac2fifoc && fs_fifoc2cs))
    else begin
        $error("fs_mac2fifoc and fs_fifoc2cs high together");
        fail_count++;
    end

    // no new payload accepted while a frame is in flight
    a_rx_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (fs_mac2fifoc || fs_fifoc2cs) |-> !fs_udp_rx)
    else begin
        $error("fs_udp_rx high during copy or parse");
        fail_count++;
    end

    a_no_overflow: assert property (@(posedge gmii_rxc) disable iff (!rst_n)
        !(fifoc_txen && fifoc_full))
    else begin
        $error("command FIFO written while full");
        fail_count++;
    end

endmodule

bind cmd_rx_top cmd_rx_sva rx_sva (
    .clk(clk),
    .gmii_rxc(gmii_rxc),
    .rst_n(rst_n),
    .fs_udp_rx(fs_udp_rx),
    .fs_mac2fifoc(fs_mac2fifoc),
    .fs_fifoc2cs(fs_fifoc2cs),
    .fifoc_txen(fifoc_txen),
    .fifoc_full(fifoc_full)
);

`default_nettype wire

//--- tb_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_rx;

    localparam int WAIT_LIMIT = 5000;

    logic                               gmii_rxc;
    logic                               clk;
    logic                               rst_n;
    logic [7:0]                         udp_rxd;
    eth_pkg::udp_len_t                  udp_rx_len;
    logic                               fd_udp_rx;
    logic                               up;
    logic                               down;
    logic                               fs_udp_rx;
    logic [eth_pkg::PAYLOAD_ADDR_W-1:0] udp_rx_addr;
    cmd_pkg::cmd_regs_u                 cmd_regs;
    cmd_pkg::frame_cnt_t                frame_cnt;
    logic                               err_fifoc2cs;
    logic                               fifoc_full;
    logic [31:0]                        led;

    // MAC payload buffer
    logic [7:0] ram [eth_pkg::PAYLOAD_MAX];

    cmd_pkg::cmd_regs_u  exp_regs;
    cmd_pkg::frame_cnt_t exp_cnt;
    int                  errors;
    int                  checks;
    int                  tests;
    int                  test_start;
    int                  err_pulses;
    logic                full_seen;

    cmd_rx_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        gmii_rxc = 1'b0;
        forever #4 gmii_rxc = ~gmii_rxc;
    end

    // buffer read data follows the address by one gmii_rxc cycle
    always @(posedge gmii_rxc) begin
        udp_rxd <= ram[udp_rx_addr];
    end

    always @(negedge clk) begin
        if (rst_n && err_fifoc2cs) begin
            err_pulses++;
        end
    end

    // full flag moves with gmii_rxc, so look between its edges
    always @(negedge gmii_rxc) begin
        if (rst_n && fifoc_full) begin
            full_seen = 1'b1;
        end
    end

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_regs(input cmd_pkg::cmd_regs_u got, input cmd_pkg::cmd_regs_u exp);
        compare_byte("cmd_regs.kind_dev", got.f.kind_dev, exp.f.kind_dev);
        compare_byte("cmd_regs.info_sr", got.f.info_sr, exp.f.info_sr);
        compare_byte("cmd_regs.cmd_filt", got.f.cmd_filt, exp.f.cmd_filt);
        compare_byte("cmd_regs.cmd_mix0", got.f.cmd_mix0, exp.f.cmd_mix0);
        compare_byte("cmd_regs.cmd_mix1", got.f.cmd_mix1, exp.f.cmd_mix1);
        compare_byte("cmd_regs.cmd_reg4", got.f.cmd_reg4, exp.f.cmd_reg4);
        compare_byte("cmd_regs.cmd_reg5", got.f.cmd_reg5, exp.f.cmd_reg5);
        compare_byte("cmd_regs.cmd_reg6", got.f.cmd_reg6, exp.f.cmd_reg6);
        compare_byte("cmd_regs.cmd_reg7", got.f.cmd_reg7, exp.f.cmd_reg7);
    endtask

    task automatic check_cnt(input cmd_pkg::frame_cnt_t got, input cmd_pkg::frame_cnt_t exp);
        compare_byte("frame_cnt.ok_count", got.ok_count, exp.ok_count);
        compare_byte("frame_cnt.err_count", got.err_count, exp.err_count);
    endtask

    task automatic check_led(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR led got 0x%08h expected 0x%08h", got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_pulses(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR err_fifoc2cs pulses got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic wait_fs(input logic want);
        int n;
        n = 0;
        while (fs_udp_rx !== want && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (fs_udp_rx !== want) begin
            $display("timeout: fs_udp_rx never went to %0b", want);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    // random payload, then header and checksum laid over it
    task automatic build_frame(input bit bad_hdr, input bit bad_chk);
        logic [7:0] x;
        x = 8'h00;
        for (int i = 0; i < eth_pkg::PAYLOAD_MAX; i++) begin
            ram[i] = 8'($urandom);
        end
        ram[0] = bad_hdr ? 8'hAA : 8'h55;
        for (int i = 1; i <= 9; i++) begin
            x = x ^ ram[i];
        end
        ram[10] = bad_chk ? ~x : x;
    endtask

    task automatic send_frame(input int len);
        logic [7:0] x;
        logic       good;
        @(negedge clk);
        udp_rx_len = 16'(len);
        fd_udp_rx  = 1'b1;
        wait_fs(1'b0);
        @(negedge clk);
        fd_udp_rx = 1'b0;
        wait_fs(1'b1);
        // reference model of the frame rules
        x = 8'h00;
        for (int i = 1; i <= 9; i++) begin
            x = x ^ ram[i];
        end
        good = (len == 11) && (ram[0] == 8'h55) && (ram[10] == x);
        if (good) begin
            for (int i = 1; i <= 9; i++) begin
                exp_regs.bytes[i - 1] = ram[i];
            end
            exp_cnt.ok_count = exp_cnt.ok_count + 8'd1;
        end else begin
            exp_cnt.err_count = exp_cnt.err_count + 8'd1;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_start) ? "ok" : "fail");
        test_start = errors;
    endtask

    function automatic logic [31:0] led_word(input int p);
        logic [7:0] v [12];
        for (int i = 0; i < 9; i++) begin
            v[i] = exp_regs.bytes[i];
        end
        v[9]  = exp_cnt.ok_count;
        v[10] = exp_cnt.err_count;
        v[11] = 8'h1B;
        return {v[4*p+3], v[4*p+2], v[4*p+1], v[4*p]};
    endfunction

    task automatic pulse_key(input bit step_up);
        @(negedge clk);
        up   = step_up;
        down = !step_up;
        @(negedge clk);
        up   = 1'b0;
        down = 1'b0;
    endtask

    task automatic test_reset;
        repeat (16) begin
            @(negedge clk);
            check_level("fs_udp_rx", fs_udp_rx, 1'b0);
        end
        rst_n = 1'b1;
        wait_fs(1'b1);
        check_regs(cmd_regs, '0);
        check_cnt(frame_cnt, '0);
        check_led(led, 32'h0);
        check_level("fifoc_full", fifoc_full, 1'b0);
        end_test("reset state");
    endtask

    task automatic test_good;
        build_frame(1'b0, 1'b0);
        send_frame(11);
        check_regs(cmd_regs, exp_regs);
        check_cnt(frame_cnt, exp_cnt);
        end_test("good frame");
    endtask

    task automatic test_reject;
        int p0;
        p0 = err_pulses;
        build_frame(1'b1, 1'b0);
        send_frame(11);
        build_frame(1'b0, 1'b1);
        send_frame(11);
        build_frame(1'b0, 1'b0);
        send_frame(10);
        build_frame(1'b0, 1'b0);
        send_frame(40);
        check_regs(cmd_regs, exp_regs);
        check_cnt(frame_cnt, exp_cnt);
        check_pulses(err_pulses - p0, 4);
        build_frame(1'b0, 1'b0);
        send_frame(11);
        check_regs(cmd_regs, exp_regs);
        check_cnt(frame_cnt, exp_cnt);
        end_test("rejected frames");
    endtask

    task automatic test_burst;
        int k;
        for (int n = 0; n < 8; n++) begin
            k = $urandom % 4;
            case (k)
                0: build_frame(1'b0, 1'b0);
                1: build_frame(1'b1, 1'b0);
                2: build_frame(1'b0, 1'b1);
                default: build_frame(1'b0, 1'b0);
            endcase
            send_frame((k == 3) ? 1 + ($urandom % 64) : 11);
        end
        check_regs(cmd_regs, exp_regs);
        check_cnt(frame_cnt, exp_cnt);
        end_test("back-to-back frames");
    endtask

    task automatic test_led;
        @(negedge clk);
        check_led(led, led_word(0));
        pulse_key(1'b1);
        check_led(led, led_word(1));
        pulse_key(1'b1);
        check_led(led, led_word(2));
        pulse_key(1'b1);
        check_led(led, led_word(0));
        // wraps backwards from the first page
        pulse_key(1'b0);
        check_led(led, led_word(2));
        end_test("led paging");
    endtask

    task automatic test_oversize;
        int p0;
        p0 = err_pulses;
        full_seen = 1'b0;
        build_frame(1'b0, 1'b0);
        send_frame(100);
        // 64 bytes fill the FIFO before the parser starts
        check_level("fifoc_full during copy", full_seen, 1'b1);
        check_cnt(frame_cnt, exp_cnt);
        check_pulses(err_pulses - p0, 1);
        build_frame(1'b0, 1'b0);
        send_frame(11);
        check_regs(cmd_regs, exp_regs);
        check_cnt(frame_cnt, exp_cnt);
        check_level("fifoc_full", fifoc_full, 1'b0);
        end_test("oversize payload");
    endtask

    initial begin
        int total;
        void'($urandom(5138));
        errors     = 0;
        checks     = 0;
        tests      = 0;
        test_start = 0;
        err_pulses = 0;
        full_seen  = 1'b0;
        rst_n      = 1'b0;
        fd_udp_rx  = 1'b0;
        up         = 1'b0;
        down       = 1'b0;
        udp_rx_len = '0;
        udp_rxd    = 8'h00;
        exp_regs   = '0;
        exp_cnt    = '0;
        for (int i = 0; i < eth_pkg::PAYLOAD_MAX; i++) begin
            ram[i] = 8'(i) ^ 8'h5A;
        end
        test_reset;
        test_good;
        test_reject;
        test_burst;
        test_led;
        test_oversize;
        total = errors + UUT.rx_sva.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
eth_pkg.sv
cmd_pkg.sv
mac2fifoc.sv
fifoc.sv
fifoc2cs.sv
cs.sv
led.sv
cmd_rx_top.sv
cmd_rx_sva.sv
tb_cmd_rx.sv
